// ==== logic/rvPkg.sv ====
`default_nettype none

package rvPkg;

    typedef logic [31:0] word_t;    // data, address or instruction word
    typedef logic [4:0]  regIdx_t;  // register index
    typedef logic [7:0]  imemAddr_t;  // word index into instruction store

    localparam int    IMEM_WORDS = 256;  // instruction store depth
    localparam int    NUM_REGS   = 32;   // integer register file depth
    localparam word_t RESET_PC   = 32'h0000_0000;  // first fetch after reset or run

    // internal operation, add and addi share OP_ADD
    typedef enum logic [2:0] {
        OP_NOP,  // illegal or unsupported word
        OP_ADD,
        OP_SUB,
        OP_BEQ,
        OP_BLT,  // signed compare
        OP_JAL
    } op_e;

    // major opcode field, bits 6..0 of the instruction
    typedef enum logic [6:0] {
        OPC_IMM    = 7'b0010011,  // addi and friends
        OPC_REG    = 7'b0110011,  // add, sub and friends
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } rvOpc_e;

    localparam logic [2:0] F3_ADD = 3'b000;  // addi, add, sub
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BLT = 3'b100;

    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

`default_nettype wire

// ==== logic/decExIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decExIf;
    import rvPkg::*;

    logic    valid;   // slot holds a live instruction
    word_t   pc;      // address of the instruction
    op_e     op;
    regIdx_t rd;      // 0 when nothing is written
    logic    useImm;  // second ALU operand is imm, not rs2
    word_t   rs1Val;  // forwarded operand values
    word_t   rs2Val;
    word_t   imm;     // sign extended I, B or J immediate

    modport decode (
        output valid, pc, op, rd, useImm,
        output rs1Val, rs2Val, imm
    );

    modport execute (
        input valid, pc, op, rd, useImm,
        input rs1Val, rs2Val, imm
    );

endinterface

`default_nettype wire

// ==== logic/instrMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrMem (
    input  wire logic             clk,
    input  wire logic             progWe,    // load strobe, only with run low
    input  rvPkg::imemAddr_t      progAddr,  // word index
    input  rvPkg::word_t          progData,
    input  rvPkg::word_t          readAddr,  // byte address from fetch
    output rvPkg::word_t          readData
);
    import rvPkg::*;

    word_t     mem [IMEM_WORDS];  // program store, contents survive reset
    imemAddr_t readIdx;

    assign readIdx = readAddr[9:2];  // drop byte offset, keep word alignment

    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign readData = mem[readIdx];  // async read, same cycle as the PC

    // a load may only hit the word under fetch while fetch is parked on it
    wordWriteVsFetch: assert property (
        @(posedge clk) (progWe && progAddr == readIdx) |-> $stable(readAddr)
    ) else $error("instrMem: word %0d written while being fetched", progAddr);

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire logic    clk,
    input  wire logic    arstN,
    input  wire logic    run,         // level, low parks fetch at RESET_PC
    input  wire logic    redirect,    // one cycle pulse from execute
    input  rvPkg::word_t redirectPc,
    output rvPkg::word_t imemAddr,
    input  rvPkg::word_t imemData,
    output logic         fetchValid,
    output rvPkg::word_t fetchPc,
    output rvPkg::word_t fetchInstr
);
    import rvPkg::*;

    word_t pc;  // address being fetched this cycle

    assign imemAddr = pc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= RESET_PC;
            fetchValid <= 1'b0;
        end else begin
            if (!run) begin
                pc <= RESET_PC;  // hold at start while stopped
            end else if (redirect) begin
                pc <= redirectPc;  // taken branch or jal wins over step
            end else begin
                pc <= pc + 32'd4;
            end
            fetchValid <= run && !redirect;  // kill the word fetched behind a redirect
        end
    end

    // fetch/decode payload
    always_ff @(posedge clk) begin
        fetchPc    <= pc;
        fetchInstr <= imemData;
    end

    redirectAligned: assert property (
        @(posedge clk) disable iff (!arstN) redirect |-> (redirectPc[1:0] == 2'b00)
    ) else $error("fetchStage: misaligned redirect to %h", redirectPc);

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire logic       clk,
    input  wire logic       arstN,
    input  wire logic       fetchValid,
    input  rvPkg::word_t    fetchPc,
    input  rvPkg::word_t    fetchInstr,
    input  wire logic       redirect,  // kills the slot entering execute
    input  wire logic       wbWe,
    input  rvPkg::regIdx_t  wbRd,
    input  rvPkg::word_t    wbData,
    decExIf.decode          decEx
);
    import rvPkg::*;

    word_t      regFile [NUM_REGS];  // x0 held at zero
    regIdx_t    rs1;
    regIdx_t    rs2;
    regIdx_t    rdField;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      immI;
    word_t      immB;
    word_t      immJ;
    op_e        op;
    regIdx_t    rd;
    logic       useImm;
    word_t      imm;
    word_t      rs1Val;
    word_t      rs2Val;

    assign rs1     = fetchInstr[19:15];
    assign rs2     = fetchInstr[24:20];
    assign rdField = fetchInstr[11:7];
    assign funct3  = fetchInstr[14:12];
    assign funct7  = fetchInstr[31:25];

    assign immI = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
    assign immB = {{20{fetchInstr[31]}}, fetchInstr[7], fetchInstr[30:25],
                   fetchInstr[11:8], 1'b0};
    assign immJ = {{12{fetchInstr[31]}}, fetchInstr[19:12], fetchInstr[20],
                   fetchInstr[30:21], 1'b0};

    always_comb begin
        op     = OP_NOP;  // anything unknown retires as a no-op
        rd     = '0;
        useImm = 1'b0;
        imm    = '0;
        case (fetchInstr[6:0])
            OPC_IMM: begin
                if (funct3 == F3_ADD) begin  // addi
                    op     = OP_ADD;
                    rd     = rdField;
                    useImm = 1'b1;
                    imm    = immI;
                end
            end
            OPC_REG: begin
                if (funct3 == F3_ADD && funct7 == F7_ADD) begin
                    op = OP_ADD;
                    rd = rdField;
                end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    op = OP_SUB;
                    rd = rdField;
                end
            end
            OPC_BRANCH: begin
                imm = immB;  // rd stays 0, branches write nothing
                if (funct3 == F3_BEQ) begin
                    op = OP_BEQ;
                end else if (funct3 == F3_BLT) begin
                    op = OP_BLT;
                end
            end
            OPC_JAL: begin
                op  = OP_JAL;
                rd  = rdField;  // link register
                imm = immJ;
            end
            default: ;
        endcase
    end

    // operand read with bypass from write-back, x0 never forwarded
    assign rs1Val = (rs1 == '0) ? '0 :
                    (wbWe && wbRd == rs1) ? wbData : regFile[rs1];
    assign rs2Val = (rs2 == '0) ? '0 :
                    (wbWe && wbRd == rs2) ? wbData : regFile[rs2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbWe) begin
            regFile[wbRd] <= wbData;  // execute never targets x0
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decEx.valid <= 1'b0;
        end else begin
            decEx.valid <= fetchValid && !redirect;
        end
    end

    // decode/execute payload
    always_ff @(posedge clk) begin
        decEx.pc     <= fetchPc;
        decEx.op     <= op;
        decEx.rd     <= rd;
        decEx.useImm <= useImm;
        decEx.rs1Val <= rs1Val;
        decEx.rs2Val <= rs2Val;
        decEx.imm    <= imm;
    end

    x0StaysZero: assert property (
        @(posedge clk) disable iff (!arstN) regFile[0] == '0
    ) else $error("decodeStage: x0 holds %h", regFile[0]);

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic        clk,
    input  wire logic        arstN,
    decExIf.execute          decEx,
    output logic             wbWe,
    output rvPkg::regIdx_t   wbRd,
    output rvPkg::word_t     wbData,
    output logic             redirect,    // one cycle, taken branch or jal
    output rvPkg::word_t     redirectPc,
    output logic             retireValid,
    output rvPkg::word_t     retirePc,
    output rvPkg::regIdx_t   retireRd,
    output rvPkg::word_t     retireData
);
    import rvPkg::*;

    word_t aluB;     // imm or rs2
    word_t result;
    logic  doWrite;  // op produces a register value
    logic  taken;

    assign aluB = decEx.useImm ? decEx.imm : decEx.rs2Val;

    always_comb begin
        result  = '0;
        doWrite = 1'b0;
        taken   = 1'b0;
        case (decEx.op)
            OP_ADD: begin
                result  = decEx.rs1Val + aluB;
                doWrite = 1'b1;
            end
            OP_SUB: begin
                result  = decEx.rs1Val - decEx.rs2Val;
                doWrite = 1'b1;
            end
            OP_JAL: begin
                result  = decEx.pc + 32'd4;  // link value
                doWrite = 1'b1;
                taken   = 1'b1;
            end
            OP_BEQ: taken = (decEx.rs1Val == decEx.rs2Val);
            OP_BLT: taken = ($signed(decEx.rs1Val) < $signed(decEx.rs2Val));
            default: ;  // OP_NOP falls through to pc+4
        endcase
    end

    // write-back, x0 target suppressed here
    assign wbWe   = decEx.valid && doWrite && (decEx.rd != '0);
    assign wbRd   = decEx.rd;
    assign wbData = result;

    assign redirect   = decEx.valid && taken;
    assign redirectPc = decEx.pc + decEx.imm;  // branch and jal share pc+imm

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= decEx.valid;
        end
    end

    // retire report, rd 0 and data 0 when nothing was written
    always_ff @(posedge clk) begin
        retirePc   <= decEx.pc;
        retireRd   <= wbWe ? wbRd : '0;
        retireData <= wbWe ? wbData : '0;
    end

    // the slot behind a redirect is always a bubble
    redirectKillsNext: assert property (
        @(posedge clk) disable iff (!arstN) redirect |=> !decEx.valid
    ) else $error("execute: live instruction right behind redirect from %h", retirePc);

endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCore (
    input  wire logic        clk,
    input  wire logic        arstN,
    input  wire logic        progWe,     // program load, run must be low
    input  rvPkg::imemAddr_t progAddr,
    input  rvPkg::word_t     progData,
    input  wire logic        run,
    output logic             retireValid,
    output rvPkg::word_t     retirePc,
    output rvPkg::regIdx_t   retireRd,
    output rvPkg::word_t     retireData
);
    import rvPkg::*;

    word_t   imemAddr;
    word_t   imemData;
    logic    fetchValid;
    word_t   fetchPc;
    word_t   fetchInstr;
    logic    redirect;
    word_t   redirectPc;
    logic    wbWe;
    regIdx_t wbRd;
    word_t   wbData;

    decExIf decEx ();  // decode to execute bundle

    instrMem instrMem_i (
        .clk      (clk),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .readAddr (imemAddr),
        .readData (imemData)
    );

    fetchStage fetchStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr)
    );

    decodeStage decodeStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr),
        .redirect   (redirect),
        .wbWe       (wbWe),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .decEx      (decEx.decode)
    );

    executeStage executeStage_i (
        .clk         (clk),
        .arstN       (arstN),
        .decEx       (decEx.execute),
        .wbWe        (wbWe),
        .wbRd        (wbRd),
        .wbData      (wbData),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

endmodule

`default_nettype wire

// ==== verif/rvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam int      CLK_PERIOD  = 100;           // ns
    localparam int      RESET_CYC   = 16;
    localparam int      NUM_TESTS   = 25;            // 4 directed, 20 random, run control
    localparam int      MAX_RETIRES = 200;
    localparam int      NUM_RANDOM  = 20;
    localparam longint  WATCHDOG_NS =
        longint'(NUM_TESTS * MAX_RETIRES * 3 + NUM_TESTS * 300) * CLK_PERIOD;
    localparam int unsigned SEED = 32'h13c612da;

    logic      clk;
    logic      arstN;
    logic      progWe;
    imemAddr_t progAddr;
    word_t     progData;
    logic      run;
    logic      retireValid;
    word_t     retirePc;
    regIdx_t   retireRd;
    word_t     retireData;

    word_t     prog [IMEM_WORDS];  // program image, also read by the model
    word_t     mRegs [NUM_REGS];   // model register file
    word_t     mPc;
    int        expected;   // retirements asked for so far, owned by main sequence
    int        retired;    // retirements compared so far, owned by compare process
    int        testNum;
    int        modelTest;
    logic      expectIdle;  // run is low, nothing may retire
    int        errors;
    int        passed;
    int        failed;
    string     curTest;

    rvCore rvCore_i (
        .clk         (clk),
        .arstN       (arstN),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .run         (run),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t encodeI(input regIdx_t rd, input regIdx_t rs1, input word_t imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t encodeR(input logic [6:0] f7, input regIdx_t rd,
                                      input regIdx_t rs1, input regIdx_t rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic word_t encodeB(input logic [2:0] f3, input regIdx_t rs1,
                                      input regIdx_t rs2, input word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t encodeJ(input regIdx_t rd, input word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ISA model, one instruction per call
    function automatic void stepModel(output word_t pc, output regIdx_t rd, output word_t data);
        word_t   w;
        word_t   a;
        word_t   b;
        word_t   nextPc;
        regIdx_t dst;
        word_t   val;
        w      = prog[mPc[9:2]];  // word index like the fetch path
        a      = mRegs[w[19:15]];
        b      = mRegs[w[24:20]];
        nextPc = mPc + 32'd4;
        dst    = '0;
        val    = '0;
        if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin  // addi
            dst = w[11:7];
            val = a + {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 &&
                     (w[31:25] == 7'h00 || w[31:25] == 7'h20)) begin
            dst = w[11:7];
            val = w[30] ? a - b : a + b;  // sub has bit 30 set
        end else if (w[6:0] == 7'b1100011 &&
                     ((w[14:12] == 3'b000 && a == b) ||
                      (w[14:12] == 3'b100 && $signed(a) < $signed(b)))) begin
            nextPc = mPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[6:0] == 7'b1101111) begin  // jal
            dst    = w[11:7];
            val    = mPc + 32'd4;
            nextPc = mPc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        if (dst != 0) begin
            mRegs[dst] = val;
        end else begin
            val = '0;  // x0 target or no write at all
        end
        pc   = mPc;
        rd   = dst;
        data = val;
        mPc  = nextPc;
    endfunction

    task automatic checkWord(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkIdx(input string what, input regIdx_t got, input regIdx_t exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // outputs move on the rising edge, sample on the falling one
    always @(negedge clk) begin : compareRetire
        word_t   expPc;
        regIdx_t expRd;
        word_t   expData;
        if (modelTest != testNum) begin
            mPc = RESET_PC;
            for (int i = 0; i < NUM_REGS; i++) begin
                mRegs[i] = '0;
            end
            modelTest = testNum;
        end
        if (arstN && retireValid) begin
            if (retired < expected) begin
                stepModel(expPc, expRd, expData);
                checkWord("retirePc", retirePc, expPc);
                checkIdx("retireRd", retireRd, expRd);
                checkWord("retireData", retireData, expData);
                retired++;
            end else if (expectIdle) begin
                $display("test %s: an instruction retired at time %0t while run was low",
                         curTest, $time);
                errors++;
            end
        end
    end

    task automatic fillProg();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = encodeI(regIdx_t'(i % 31 + 1), 0, word_t'(i));  // addi xk, x0, addr
        end
    endtask

    task automatic buildArith();
        fillProg();
        prog[0] = encodeI(1, 0, 5);
        prog[1] = encodeI(2, 1, -3);            // needs x1 right behind it
        prog[2] = encodeR(7'h00, 3, 2, 1);
        prog[3] = encodeR(7'h20, 4, 3, 2);
        prog[4] = encodeR(7'h20, 4, 4, 3);      // goes negative
        prog[5] = encodeR(7'h00, 5, 4, 4);
        prog[6] = encodeI(0, 5, 7);             // x0 target
        prog[7] = encodeR(7'h00, 6, 0, 5);
        prog[8] = encodeI(6, 6, -2048);
    endtask

    task automatic buildBranch();
        fillProg();
        prog[0]  = encodeI(1, 0, -5);
        prog[1]  = encodeI(2, 0, 3);
        prog[2]  = encodeB(3'b100, 1, 2, 12);   // -5 < 3, to 20
        prog[5]  = encodeB(3'b100, 2, 1, 8);    // not taken
        prog[6]  = encodeB(3'b000, 1, 1, 12);   // to 36
        prog[9]  = encodeB(3'b000, 1, 2, 8);    // not taken
        prog[10] = encodeI(3, 0, -1);
        prog[11] = encodeB(3'b100, 3, 1, 8);    // -1 < -5 false
        prog[12] = encodeB(3'b100, 1, 3, 8);    // to 56
        prog[14] = encodeB(3'b000, 0, 0, -56);  // back to 0
    endtask

    task automatic buildJump();
        fillProg();
        prog[0] = encodeI(2, 0, 3);
        prog[1] = encodeJ(5, 16);               // forward, link 8
        prog[5] = encodeI(1, 1, 1);
        prog[6] = encodeB(3'b100, 1, 2, -4);    // count x1 up to 3
        prog[7] = encodeJ(6, -28);              // backward to 0, link 32
    endtask

    task automatic buildIllegal();
        fillProg();
        prog[0] = 32'h0000_0000;
        prog[1] = 32'hffff_ffff;
        prog[2] = 32'h0000_2083;                // lw x1, 0(x0)
        prog[3] = 32'h0010_6093;                // ori x1, x0, 1
        prog[4] = encodeB(3'b001, 0, 0, 8);     // bne
        prog[5] = encodeR(7'h01, 1, 1, 1);      // mul
    endtask

    task automatic buildRandom();
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
        word_t   imm;
        word_t   off;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            rd  = regIdx_t'($urandom_range(7, 0));  // few regs, many dependencies
            rs1 = regIdx_t'($urandom_range(7, 0));
            rs2 = regIdx_t'($urandom_range(7, 0));
            imm = word_t'($urandom_range(63, 0)) - 32'd32;
            off = (word_t'($urandom_range(16, 0)) - 32'd8) << 2;  // word aligned
            case ($urandom_range(5, 0))
                0: prog[i] = encodeI(rd, rs1, imm);
                1: prog[i] = encodeR(7'h00, rd, rs1, rs2);
                2: prog[i] = encodeR(7'h20, rd, rs1, rs2);
                3: prog[i] = encodeB(3'b000, rs1, rs2, off);
                4: prog[i] = encodeB(3'b100, rs1, rs2, off);
                default: prog[i] = encodeJ(rd, off);
            endcase
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        arstN  = 1'b0;
        run    = 1'b0;
        progWe = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        arstN = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = imemAddr_t'(i);
            progData = prog[i];
        end
        @(negedge clk);
        progWe = 1'b0;
    endtask

    task automatic runTest(input string name, input int nRet, input int idleCycles);
        int cycles;
        int errBefore;
        curTest   = name;
        errBefore = errors;
        applyReset();
        expectIdle = 1'b1;
        repeat (idleCycles) @(negedge clk);  // run low, nothing may retire
        loadProgram();
        testNum++;  // model restarts at PC 0
        expected   = retired + nRet;
        expectIdle = 1'b0;
        @(negedge clk);
        run    = 1'b1;
        cycles = 0;
        while (retired < expected && cycles < nRet * 3 + 20) begin
            @(negedge clk);
            cycles++;
        end
        run = 1'b0;
        if (retired < expected) begin
            $display("test %s: stalled, %0d of %0d retirements never came",
                     name, expected - retired, nRet);
            expected = retired;
            failed++;
        end else if (errors != errBefore) begin
            $display("test %s: %0d mismatches", name, errors - errBefore);
            failed++;
        end else begin
            $display("test %s: %0d retirements ok", name, nRet);
            passed++;
        end
    endtask

    initial begin : mainSeq
        arstN      = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        run        = 1'b0;
        expected   = 0;
        retired    = 0;
        testNum    = 0;
        modelTest  = 0;
        expectIdle = 1'b0;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        curTest    = "setup";
        void'($urandom(SEED));
        buildArith();
        runTest("arithmetic chain", 12, 0);
        buildBranch();
        runTest("branches", 24, 0);
        buildJump();
        runTest("jumps", 30, 0);
        buildIllegal();
        runTest("illegal words", 10, 0);
        for (int t = 0; t < NUM_RANDOM; t++) begin
            buildRandom();
            runTest($sformatf("random program %0d", t), MAX_RETIRES, 0);
        end
        buildArith();
        runTest("run control", 12, 30);
        $display("tests %0d, passed %0d, failed %0d, value mismatches %0d",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, test %s hung and never finished", curTest);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvCore.f ====
logic/rvPkg.sv
logic/decExIf.sv
logic/instrMem.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/rvCore.sv
verif/rvCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= rvCoreTb
FILELIST  ?= rvCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
